// File: rtl/pid_pkg.sv
package pid_pkg;

    // sample path: target, measurement, error and output share one width
    typedef logic signed [15:0] sample_t;

    // fixed-point gain, Q_BITS fraction bits
    typedef logic signed [15:0] gain_t;

    // gain register address, 0 = kp, 1 = ki, 2 and 3 ignored
    typedef logic [1:0] gain_addr_t;

    // full-width product before the fraction shift
    typedef logic signed [31:0] product_t;

    // consumer steps, one arithmetic operation each
    typedef enum logic [2:0] {
        IDLE,        // wait for a queued error
        ERROR_LOAD,  // error sum for the trapezoid
        PROP,        // proportional product
        INT_MUL,     // integral increment
        INT_ACC,     // integral accumulate and clamp
        OUTPUT       // final sum, clamp and strobe
    } core_state_t;

    localparam gain_addr_t ADDR_KP = 2'd0;
    localparam gain_addr_t ADDR_KI = 2'd1;

    localparam int      DEF_Q_BITS     = 13;   // 1.0 == 8192
    localparam sample_t DEF_LIM_MAX    = 16'sd4096;
    localparam sample_t DEF_LIM_MIN    = -16'sd4096;
    localparam int      DEF_FIFO_DEPTH = 4;    // power of two

endpackage

// File: rtl/error_stream_if.sv
interface error_stream_if (
    input logic clk
);
    import pid_pkg::*;

    logic    push;        // producer strobe
    sample_t push_error;  // error being pushed
    logic    full;
    logic    pop;         // consumer strobe
    sample_t head_error;  // oldest queued error, valid while !empty
    logic    empty;

    modport producer (
        input  clk, full,
        output push, push_error
    );

    modport buffer (
        input  clk, push, push_error, pop,
        output full, empty, head_error
    );

    modport consumer (
        input  clk, head_error, empty,
        output pop
    );

endinterface

// File: rtl/error_sampler.sv
module error_sampler (
    input  logic                 clk,
    input  logic                 rstb,
    input  logic                 sample,
    input  pid_pkg::sample_t     target,
    input  pid_pkg::sample_t     measurement,
    output logic                 overrun,
    error_stream_if.producer     stream
);
    import pid_pkg::*;

    sample_t error_next;
    logic    strobe_q;    // strobe taken at the last edge

    // subtraction wraps at the sample width
    assign error_next = target - measurement;

    // full is checked in the push cycle itself
    assign stream.push = strobe_q && !stream.full;
    assign overrun     = strobe_q && stream.full;  // dropped sample

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= sample;              // one-cycle push per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            stream.push_error <= error_next;  // held until next strobe
        end
    end

endmodule

// File: rtl/error_fifo.sv
module error_fifo #(
    parameter int FIFO_DEPTH = pid_pkg::DEF_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           rstb,
    error_stream_if.buffer stream
);
    import pid_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    sample_t        mem [FIFO_DEPTH];
    logic  [AW:0]   wr_ptr;   // extra msb tells full from empty
    logic  [AW:0]   rd_ptr;
    logic           do_push;
    logic           do_pop;

    assign stream.empty = (wr_ptr == rd_ptr);
    assign stream.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                          (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // show-ahead read
    assign stream.head_error = mem[rd_ptr[AW-1:0]];

    assign do_push = stream.push && !stream.full;
    assign do_pop  = stream.pop && !stream.empty;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= stream.push_error;
        end
    end

endmodule

// File: rtl/pi_core.sv
module pi_core #(
    parameter int               Q_BITS  = pid_pkg::DEF_Q_BITS,
    parameter pid_pkg::sample_t LIM_MAX = pid_pkg::DEF_LIM_MAX,
    parameter pid_pkg::sample_t LIM_MIN = pid_pkg::DEF_LIM_MIN
) (
    input  logic                 clk,
    input  logic                 rstb,
    input  logic                 write_enable,
    input  pid_pkg::gain_addr_t  reg_addr,
    input  pid_pkg::gain_t       reg_data,
    error_stream_if.consumer     stream,
    output pid_pkg::sample_t     out,
    output logic                 out_valid
);
    import pid_pkg::*;

    core_state_t state;

    gain_t    kp;
    gain_t    ki;
    sample_t  e_prev;    // history, cleared on gain write
    sample_t  integ;     // clamped integral

    sample_t  e_cur;
    sample_t  err_sum;   // e + e_prev, wraps like the error
    product_t p_term;
    product_t inc;
    logic     take;

    function automatic sample_t clamp(input product_t v);
        if (v > product_t'(LIM_MAX)) begin
            return LIM_MAX;
        end else if (v < product_t'(LIM_MIN)) begin
            return LIM_MIN;
        end
        return sample_t'(v);
    endfunction

    // gain write wins so a queued error is never lost
    assign take       = (state == IDLE) && !stream.empty && !write_enable;
    assign stream.pop = take;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state     <= IDLE;
            kp        <= '0;
            ki        <= '0;
            e_prev    <= '0;
            integ     <= '0;
            out       <= '0;
            out_valid <= 1'b0;
        end else if (write_enable) begin
            case (reg_addr)
                ADDR_KP: kp <= reg_data;
                ADDR_KI: ki <= reg_data;
                default: ;               // no derivative gains
            endcase
            state     <= IDLE;           // abort in-flight work
            e_prev    <= '0;
            integ     <= '0;
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= ERROR_LOAD;
                    end
                end
                ERROR_LOAD: begin
                    e_prev <= e_cur;     // sum is taken this same edge
                    state  <= PROP;
                end
                PROP: begin
                    state <= INT_MUL;
                end
                INT_MUL: begin
                    state <= INT_ACC;
                end
                INT_ACC: begin
                    integ <= clamp(product_t'(integ) + inc);  // anti-windup
                    state <= OUTPUT;
                end
                OUTPUT: begin
                    out       <= clamp(p_term + product_t'(integ));
                    out_valid <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath registers, sequenced by the state above
    always_ff @(posedge clk) begin
        if (take) begin
            e_cur <= stream.head_error;
        end
        case (state)
            ERROR_LOAD: err_sum <= e_cur + e_prev;
            PROP:       p_term  <= product_t'(kp * e_cur) >>> Q_BITS;
            INT_MUL:    inc     <= product_t'(ki * err_sum) >>> Q_BITS;
            default: ;
        endcase
    end

endmodule

// File: rtl/pid_top.sv
module pid_top #(
    parameter int               Q_BITS     = pid_pkg::DEF_Q_BITS,
    parameter pid_pkg::sample_t LIM_MAX    = pid_pkg::DEF_LIM_MAX,
    parameter pid_pkg::sample_t LIM_MIN    = pid_pkg::DEF_LIM_MIN,
    parameter int               FIFO_DEPTH = pid_pkg::DEF_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rstb,
    input  logic                 sample,        // take target and measurement
    input  pid_pkg::sample_t     target,
    input  pid_pkg::sample_t     measurement,
    input  logic                 write_enable,
    input  pid_pkg::gain_addr_t  reg_addr,
    input  pid_pkg::gain_t       reg_data,
    output pid_pkg::sample_t     out,
    output logic                 out_valid,
    output logic                 overrun        // sample dropped, fifo full
);

    error_stream_if stream (.clk(clk));

    error_sampler error_sampler_inst (
        .clk         (clk),
        .rstb        (rstb),
        .sample      (sample),
        .target      (target),
        .measurement (measurement),
        .overrun     (overrun),
        .stream      (stream.producer)
    );

    error_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) error_fifo_inst (
        .clk    (clk),
        .rstb   (rstb),
        .stream (stream.buffer)
    );

    pi_core #(
        .Q_BITS  (Q_BITS),
        .LIM_MAX (LIM_MAX),
        .LIM_MIN (LIM_MIN)
    ) pi_core_inst (
        .clk          (clk),
        .rstb         (rstb),
        .write_enable (write_enable),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .stream       (stream.consumer),
        .out          (out),
        .out_valid    (out_valid)
    );

endmodule

// File: testbench/pid_assertions.sv
module pid_assertions (
    input logic clk,
    input logic rstb,
    input logic out_valid,
    input logic write_enable,
    input logic pop,
    input logic empty,
    input logic push,
    input logic full
);

    // result strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rstb) out_valid |=> !out_valid)
        else $error("out_valid high on two consecutive cycles");

    assert property (@(posedge clk) disable iff (!rstb) pop |-> !empty)
        else $error("pop while fifo empty");

    assert property (@(posedge clk) disable iff (!rstb) push |-> !full)
        else $error("push while fifo full");

    // pop, then five write-free edges, then the result
    assert property (@(posedge clk) disable iff (!rstb)
        (pop ##1 (!write_enable)[*5]) |=> out_valid)
        else $error("out_valid did not follow pop by the core latency");

endmodule

bind pi_core pid_assertions core_checks (
    .clk          (clk),
    .rstb         (rstb),
    .out_valid    (out_valid),
    .write_enable (write_enable),
    .pop          (stream.pop),
    .empty        (1'b0),
    .push         (1'b0),
    .full         (1'b0)
);

bind error_fifo pid_assertions fifo_checks (
    .clk          (clk),
    .rstb         (rstb),
    .out_valid    (1'b0),
    .write_enable (1'b1),
    .pop          (stream.pop),
    .empty        (stream.empty),
    .push         (stream.push),
    .full         (stream.full)
);

// File: testbench/tb_pid_top.sv
module tb_pid_top;
    import pid_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int KIND_WRITE  = 0;
    localparam int KIND_SAMPLE = 1;
    localparam int KIND_BURST  = 2;
    localparam int BURST_LEN   = 12;

    typedef struct packed {
        int         kind;
        int         test;
        gain_addr_t addr;
        gain_t      data;
        sample_t    tgt;
        sample_t    meas;
        int         gap;
    } row_t;

    logic       clk;
    logic       rstb;
    logic       sample;
    sample_t    target;
    sample_t    measurement;
    logic       write_enable;
    gain_addr_t reg_addr;
    gain_t      reg_data;
    sample_t    out;
    logic       out_valid;
    logic       overrun;

    row_t    rows[$];
    sample_t exp_q[$];
    gain_t   m_kp;
    gain_t   m_ki;
    sample_t m_prev;
    sample_t m_integ;
    logic    s1_valid;
    sample_t s1_err;
    logic    timing_on;     // isolated samples, latency is fixed
    int      cyc;
    int      strobe_edge;
    int      pass_count;
    int      fail_count;
    int      result_count;
    int      overrun_count;

    pid_top pid_top_inst (
        .clk          (clk),
        .rstb         (rstb),
        .sample       (sample),
        .target       (target),
        .measurement  (measurement),
        .write_enable (write_enable),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .out          (out),
        .out_valid    (out_valid),
        .overrun      (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic sample_t limit(input int v);
        if (v > int'(DEF_LIM_MAX)) return DEF_LIM_MAX;
        if (v < int'(DEF_LIM_MIN)) return DEF_LIM_MIN;
        return sample_t'(v);
    endfunction

    // PI rule applied to one accepted error
    task automatic model_step(input sample_t e);
        int      p;
        int      inc;
        sample_t esum;
        p       = (int'(m_kp) * int'(e)) >>> DEF_Q_BITS;
        esum    = sample_t'(e + m_prev);   // wraps at sample width
        inc     = (int'(m_ki) * int'(esum)) >>> DEF_Q_BITS;
        m_integ = limit(int'(m_integ) + inc);
        exp_q.push_back(limit(p + int'(m_integ)));
        m_prev  = e;
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (exp !== act) begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end else begin
            pass_count++;
        end
    endtask

    task automatic add_row(input int kind, input int test, input int a, input int b, input int gap);
        row_t r;
        r.kind = kind;
        r.test = test;
        r.addr = gain_addr_t'(a);
        r.data = gain_t'(b);
        r.tgt  = sample_t'(a);
        r.meas = sample_t'(b);
        r.gap  = gap;
        rows.push_back(r);
    endtask

    // inputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstb) begin
            cyc++;
            if (out_valid) begin
                result_count++;
                if (timing_on) begin
                    check_count("latency", 7, cyc - strobe_edge);
                end
                if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("ERROR: a result came out with no expected value pending");
                end else begin
                    check_sample("out", exp_q.pop_front(), out);
                end
            end
            if (write_enable) begin
                if (reg_addr == ADDR_KP) m_kp = reg_data;
                if (reg_addr == ADDR_KI) m_ki = reg_data;
                m_prev  = '0;
                m_integ = '0;
            end
            if (s1_valid) begin
                if (overrun) overrun_count++;
                else model_step(s1_err);
            end
            if (sample) begin
                strobe_edge = cyc + 1;   // edge that takes the strobe
            end
            s1_valid = sample;
            s1_err   = target - measurement;
        end
    end

    initial begin
        int seed;
        int wd_cycles;
        int res0;
        int ovr0;
        row_t r;

        seed = $urandom(14);
        sample = 1'b0;
        target = '0;
        measurement = '0;
        write_enable = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        rstb = 1'b0;
        timing_on = 1'b0;
        {m_kp, m_ki, m_prev, m_integ} = '0;
        {s1_valid, s1_err} = '0;
        {cyc, strobe_edge} = '0;
        {pass_count, fail_count, result_count, overrun_count} = '0;

        add_row(KIND_WRITE, 1, 0, 4096, 2);     // kp = 0.5
        add_row(KIND_WRITE, 1, 1, 0, 2);
        add_row(KIND_SAMPLE, 1, 1000, 200, 10);
        add_row(KIND_SAMPLE, 1, -500, 300, 10);
        add_row(KIND_SAMPLE, 1, 3, 0, 10);
        add_row(KIND_WRITE, 2, 0, 0, 2);
        add_row(KIND_WRITE, 2, 1, 819, 2);      // ki about 0.1
        for (int i = 0; i < 4; i++) add_row(KIND_SAMPLE, 2, 300, 200, 10);
        add_row(KIND_WRITE, 3, 0, 8192, 2);
        add_row(KIND_WRITE, 3, 1, 8192, 2);
        for (int i = 0; i < 3; i++) add_row(KIND_SAMPLE, 3, 20000, -5000, 10);
        for (int i = 0; i < 2; i++) add_row(KIND_SAMPLE, 3, -20000, 5000, 10);
        add_row(KIND_WRITE, 4, 0, 4096, 2);
        add_row(KIND_SAMPLE, 4, 400, 0, 10);
        add_row(KIND_SAMPLE, 4, 400, 0, 10);
        add_row(KIND_WRITE, 4, 1, 2000, 2);     // mid-sequence clear
        add_row(KIND_SAMPLE, 4, 400, 0, 10);
        add_row(KIND_BURST, 5, 0, 0, 120);

        wd_cycles = 200;
        foreach (rows[i]) begin
            wd_cycles += rows[i].gap + 2;
            if (rows[i].kind == KIND_SAMPLE) wd_cycles += 7;
            if (rows[i].kind == KIND_BURST) wd_cycles += 7 * BURST_LEN;
        end
        fork
            begin
                #(wd_cycles * CLK_PERIOD);
                $display("ERROR: watchdog expired after %0d cycles", wd_cycles);
                $display("Regression failed");
                $finish;
            end
        join_none

        repeat (4) @(posedge clk);
        #5 rstb = 1'b1;

        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            #5;
            timing_on = (r.kind == KIND_SAMPLE);
            if (r.kind == KIND_WRITE) begin
                write_enable = 1'b1;
                reg_addr = r.addr;
                reg_data = r.data;
                @(posedge clk);
                #5 write_enable = 1'b0;
            end else if (r.kind == KIND_SAMPLE) begin
                sample = 1'b1;
                target = r.tgt;
                measurement = r.meas;
                @(posedge clk);
                #5 sample = 1'b0;
            end else begin
                res0 = result_count;
                ovr0 = overrun_count;
                for (int k = 0; k < BURST_LEN; k++) begin
                    sample = 1'b1;
                    target = sample_t'(int'($urandom_range(2000)) - 1000);
                    measurement = '0;
                    @(posedge clk);
                    #5;
                end
                sample = 1'b0;
            end
            repeat (r.gap) @(posedge clk);
            if (r.kind == KIND_BURST) begin
                check_count("burst_total", BURST_LEN,
                            (result_count - res0) + (overrun_count - ovr0));
                check_flag("overrun_seen", 1'b1, overrun_count > ovr0);
            end
            if (i == rows.size() - 1 || rows[i + 1].test != r.test) begin
                $display("test %0d finished, %0d failures so far", r.test, fail_count);
            end
        end

        repeat (20) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_count++;
            $display("ERROR: %0d expected results never came out", exp_q.size());
        end
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/pid_pkg.sv
rtl/error_stream_if.sv
rtl/error_sampler.sv
rtl/error_fifo.sv
rtl/pi_core.sv
rtl/pid_top.sv
testbench/pid_assertions.sv
testbench/tb_pid_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_pid_top -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Regression passed$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
